/* tb/drone_testdata.txt */
1100 1128 1128 1128 0 0 0 1100 1100 1100 1100
1100 1128 1168 1128 0 0 0 1120 1080 1080 1120
1100 1128 1128 1088 0 0 0 1080 1080 1120 1120
1150 1178 1128 1128 0 0 0 1125 1175 1125 1175
1120 1128 1127 1131 0 0 0 1120 1122 1120 1118
1130 1178 1168 1088 50 40 -40 1130 1130 1130 1130
1128 1128 1128 1128 20 -30 10 1148 1098 1128 1138
950 1128 1128 1128 0 0 0 1000 1000 1000 1000
1400 1128 1128 1128 0 0 0 1255 1255 1255 1255
1240 1128 1255 1255 0 0 0 1255 1240 1114 1240
1020 1255 1000 1255 0 0 0 1000 1210 1000 1000
1100 1128 1128 1128 -1000 0 0 1000 1255 1000 1255

/* src.f */
+incdir+include
source/drone_pkg.sv
source/us_timebase.sv
source/rc_receiver.sv
source/rate_controller.sv
source/motor_mixer.sv
source/esc_pwm_generator.sv
source/drone_ctrl.sv
tb/tb_drone_ctrl.sv

/* Bender.yml */
package:
  name: drone_ctrl

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/drone_pkg.sv
      - source/us_timebase.sv
      - source/rc_receiver.sv
      - source/rate_controller.sv
      - source/motor_mixer.sv
      - source/esc_pwm_generator.sv
      - source/drone_ctrl.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_drone_ctrl.sv

/* tb/tb_drone_ctrl.sv */
`include "drone_params.svh"

module tb_drone_ctrl import drone_pkg::*; ();

	localparam int    DRIVE_DELAY      = 5; // Inputs change this long after the rising edge
	localparam int    PULSE_GAP        = 50; // Low cycles between two RC pulses
	localparam int    CYCLES_PER_FRAME = `ESC_FRAME_US * `SYS_CLK_PER_US;
	localparam string DATA_FILE        = "tb/drone_testdata.txt";

	logic       sys_clk;
	logic       rst_n;
	logic       throttle_pwm;
	logic       yaw_pwm;
	logic       roll_pwm;
	logic       pitch_pwm;
	rate_t      yaw_gyro;
	rate_t      roll_gyro;
	rate_t      pitch_gyro;
	logic       motor_1_pwm;
	logic       motor_2_pwm;
	logic       motor_3_pwm;
	logic       motor_4_pwm;
	logic [3:0] motor_pwm; // Motor pins with motor 1 in bit 0
	int         measured_us [4]; // Last measured high time per motor pin
	int         measured_rem [4]; // Cycles left over after the division

	assign motor_pwm = {motor_4_pwm, motor_3_pwm, motor_2_pwm, motor_1_pwm};

	drone_ctrl drone_ctrl_inst (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.throttle_pwm(throttle_pwm), .yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm), .pitch_pwm(pitch_pwm),
		.yaw_gyro(yaw_gyro), .roll_gyro(roll_gyro), .pitch_gyro(pitch_gyro),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm));

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk; // Period of 40
	end

	task automatic check_value(input string name, input int actual, input int expected);
		if (actual !== expected) begin
			$display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out while waiting for %s", what);
		$display("TEST FAILED");
		$fatal(1, "Wait limit reached");
	endtask

	// Channel order matches the data file, throttle, yaw, roll, pitch
	task automatic set_rc_pin(input int channel, input logic level);
		case (channel)
			0: throttle_pwm = level;
			1: yaw_pwm = level;
			2: roll_pwm = level;
			default: pitch_pwm = level;
		endcase
	endtask

	task automatic drive_pulse(input int channel, input int width_us);
		@(posedge sys_clk);
		#DRIVE_DELAY;
		set_rc_pin(channel, 1'b1);
		repeat (width_us * `SYS_CLK_PER_US) @(posedge sys_clk); // High for exactly the width
		#DRIVE_DELAY;
		set_rc_pin(channel, 1'b0);
		repeat (PULSE_GAP) @(posedge sys_clk);
	endtask

	// Returns on the first falling clock edge that sees motor 1 high again
	task automatic wait_frame_start();
		int waited;
		waited = 0;
		@(negedge sys_clk);
		while (motor_1_pwm && waited < CYCLES_PER_FRAME) begin
			@(negedge sys_clk);
			waited++;
		end
		if (motor_1_pwm) report_timeout("motor_1_pwm to go low");
		waited = 0;
		while (!motor_1_pwm && waited < CYCLES_PER_FRAME) begin
			@(negedge sys_clk);
			waited++;
		end
		if (!motor_1_pwm) report_timeout("the next ESC frame to start");
	endtask

	// All pins rise together at frame start, so one pass counts every pin
	task automatic measure_frame();
		int high_cycles [4];
		int waited;
		for (int i = 0; i < 4; i++) begin
			high_cycles[i] = int'(motor_pwm[i]);
		end
		waited = 0;
		while (motor_pwm != 4'b0000 && waited < CYCLES_PER_FRAME) begin
			@(negedge sys_clk); // Sample away from the edge that moves the pins
			waited++;
			for (int i = 0; i < 4; i++) begin
				if (motor_pwm[i]) high_cycles[i]++;
			end
		end
		if (motor_pwm != 4'b0000) report_timeout("the motor pulses to end");
		for (int i = 0; i < 4; i++) begin
			measured_us[i]  = high_cycles[i] / `SYS_CLK_PER_US;
			measured_rem[i] = high_cycles[i] % `SYS_CLK_PER_US;
		end
	endtask

	task automatic check_motors(input int vec_num, input int exp_us [4]);
		for (int i = 0; i < 4; i++) begin
			check_value($sformatf("motor_%0d_pwm width, vector %0d", i + 1, vec_num),
				measured_us[i], exp_us[i]);
			check_value($sformatf("motor_%0d_pwm cycle remainder, vector %0d", i + 1, vec_num),
				measured_rem[i], 0); // Pulses are whole microseconds
		end
	endtask

	initial begin
		int fd;
		int fields;
		int vec_num;
		int rc_us [4];
		int gyro [3];
		int exp_us [4];
		throttle_pwm = 1'b0;
		yaw_pwm      = 1'b0;
		roll_pwm     = 1'b0;
		pitch_pwm    = 1'b0;
		yaw_gyro     = '0;
		roll_gyro    = '0;
		pitch_gyro   = '0;
		rst_n        = 1'b0;
		repeat (4) @(posedge sys_clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// Before any RC frame the generator runs at rate 0
		wait_frame_start();
		measure_frame();
		check_motors(0, '{`ESC_MIN_US, `ESC_MIN_US, `ESC_MIN_US, `ESC_MIN_US});

		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file %s", DATA_FILE);
			$display("TEST FAILED");
			$fatal(1, "Missing stimulus file");
		end
		vec_num = 0;
		fields = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d",
			rc_us[0], rc_us[1], rc_us[2], rc_us[3], gyro[0], gyro[1], gyro[2],
			exp_us[0], exp_us[1], exp_us[2], exp_us[3]);
		while (fields == 11) begin
			vec_num++;
			@(posedge sys_clk);
			#DRIVE_DELAY;
			yaw_gyro   = rate_t'(gyro[0]); // Held through the frame transfer
			roll_gyro  = rate_t'(gyro[1]);
			pitch_gyro = rate_t'(gyro[2]);
			for (int ch = 0; ch < 4; ch++) begin
				drive_pulse(ch, rc_us[ch]);
			end
			// Two full frames let the new rates through the ESC back-pressure
			wait_frame_start();
			wait_frame_start();
			wait_frame_start();
			measure_frame();
			check_motors(vec_num, exp_us);
			fields = $fscanf(fd, "%d %d %d %d %d %d %d %d %d %d %d",
				rc_us[0], rc_us[1], rc_us[2], rc_us[3], gyro[0], gyro[1], gyro[2],
				exp_us[0], exp_us[1], exp_us[2], exp_us[3]);
		end
		$fclose(fd);
		if (fields != -1 || vec_num == 0) begin
			$display("The stimulus file ended early or holds a malformed line");
			$display("TEST FAILED");
			$fatal(1, "Bad stimulus file");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

/* source/drone_ctrl.sv */
module drone_ctrl import drone_pkg::*; (
	input  logic  sys_clk,
	input  logic  rst_n,
	input  logic  throttle_pwm,
	input  logic  yaw_pwm,
	input  logic  roll_pwm,
	input  logic  pitch_pwm,
	input  rate_t yaw_gyro,
	input  rate_t roll_gyro,
	input  rate_t pitch_gyro,
	output logic  motor_1_pwm,
	output logic  motor_2_pwm,
	output logic  motor_3_pwm,
	output logic  motor_4_pwm
);

	logic        us_tick;
	logic        frame_valid; // Receiver to rate loop
	logic        frame_ready;
	stick_val_t  throttle_val;
	stick_val_t  yaw_val;
	stick_val_t  roll_val;
	stick_val_t  pitch_val;
	logic        cmd_valid; // Rate loop to mixer
	logic        cmd_ready;
	stick_val_t  throttle_cmd;
	rate_t       yaw_cmd;
	rate_t       roll_cmd;
	rate_t       pitch_cmd;
	logic        motor_valid; // Mixer to ESC generator
	logic        motor_ready;
	motor_rate_t motor_1_rate;
	motor_rate_t motor_2_rate;
	motor_rate_t motor_3_rate;
	motor_rate_t motor_4_rate;

	us_timebase us_timebase_inst (.sys_clk(sys_clk), .rst_n(rst_n), .us_tick(us_tick));

	rc_receiver rc_receiver_inst (
		.sys_clk(sys_clk), .rst_n(rst_n), .us_tick(us_tick),
		.throttle_pwm(throttle_pwm), .yaw_pwm(yaw_pwm),
		.roll_pwm(roll_pwm), .pitch_pwm(pitch_pwm),
		.frame_valid(frame_valid), .frame_ready(frame_ready),
		.throttle_val(throttle_val), .yaw_val(yaw_val),
		.roll_val(roll_val), .pitch_val(pitch_val));

	rate_controller rate_controller_inst (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.frame_valid(frame_valid), .frame_ready(frame_ready),
		.throttle_val(throttle_val), .yaw_val(yaw_val),
		.roll_val(roll_val), .pitch_val(pitch_val),
		.yaw_gyro(yaw_gyro), .roll_gyro(roll_gyro), .pitch_gyro(pitch_gyro),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.throttle_cmd(throttle_cmd), .yaw_cmd(yaw_cmd),
		.roll_cmd(roll_cmd), .pitch_cmd(pitch_cmd));

	motor_mixer motor_mixer_inst (
		.sys_clk(sys_clk), .rst_n(rst_n),
		.cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
		.throttle_cmd(throttle_cmd), .yaw_cmd(yaw_cmd),
		.roll_cmd(roll_cmd), .pitch_cmd(pitch_cmd),
		.motor_valid(motor_valid), .motor_ready(motor_ready),
		.motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate));

	esc_pwm_generator esc_pwm_generator_inst (
		.sys_clk(sys_clk), .rst_n(rst_n), .us_tick(us_tick),
		.motor_valid(motor_valid), .motor_ready(motor_ready),
		.motor_1_rate(motor_1_rate), .motor_2_rate(motor_2_rate),
		.motor_3_rate(motor_3_rate), .motor_4_rate(motor_4_rate),
		.motor_1_pwm(motor_1_pwm), .motor_2_pwm(motor_2_pwm),
		.motor_3_pwm(motor_3_pwm), .motor_4_pwm(motor_4_pwm));

endmodule

/* source/esc_pwm_generator.sv */
`include "drone_params.svh"

module esc_pwm_generator import drone_pkg::*; (
	input  logic        sys_clk,
	input  logic        rst_n,
	input  logic        us_tick,
	input  logic        motor_valid,
	output logic        motor_ready,
	input  motor_rate_t motor_1_rate,
	input  motor_rate_t motor_2_rate,
	input  motor_rate_t motor_3_rate,
	input  motor_rate_t motor_4_rate,
	output logic        motor_1_pwm,
	output logic        motor_2_pwm,
	output logic        motor_3_pwm,
	output logic        motor_4_pwm
);

	localparam int FRAME_W = $clog2(`ESC_FRAME_US);
	localparam logic [FRAME_W-1:0] FRAME_LAST = FRAME_W'(`ESC_FRAME_US - 1);

	logic [FRAME_W-1:0] frame_cnt; // Microseconds since frame start
	logic               frame_wrap;
	motor_rate_t        new_rate [4];
	motor_rate_t        active [4]; // Rates shaping the current frame
	logic [3:0]         pwm_q;

	assign new_rate = '{motor_1_rate, motor_2_rate, motor_3_rate, motor_4_rate};

	// Only the wrap cycle accepts new rates, which paces the whole pipeline
	assign frame_wrap  = us_tick && (frame_cnt == FRAME_LAST);
	assign motor_ready = frame_wrap;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			frame_cnt <= FRAME_LAST; // First tick after reset starts a frame
			pwm_q     <= '0;
			for (int i = 0; i < 4; i++) begin
				active[i] <= '0;
			end
		end else begin
			if (frame_wrap) begin
				frame_cnt <= '0;
			end else if (us_tick) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
			for (int i = 0; i < 4; i++) begin
				if (frame_wrap && motor_valid) begin
					active[i] <= new_rate[i];
				end
				// High from frame start for the minimum width plus the rate
				pwm_q[i] <= frame_cnt < FRAME_W'(`ESC_MIN_US) + FRAME_W'(active[i]);
			end
		end
	end

	assign motor_1_pwm = pwm_q[0];
	assign motor_2_pwm = pwm_q[1];
	assign motor_3_pwm = pwm_q[2];
	assign motor_4_pwm = pwm_q[3];

	// Ready sits on the wrap only if all pins stay low one more cycle and then rise together
	ready_wrap_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
		motor_ready |=> (pwm_q == 4'b0000) ##1 (pwm_q == 4'b1111))
		else $error("ESC ready raised away from a frame wrap");

endmodule

/* source/motor_mixer.sv */
module motor_mixer import drone_pkg::*; (
	input  logic        sys_clk,
	input  logic        rst_n,
	input  logic        cmd_valid,
	output logic        cmd_ready,
	input  stick_val_t  throttle_cmd,
	input  rate_t       yaw_cmd,
	input  rate_t       roll_cmd,
	input  rate_t       pitch_cmd,
	output logic        motor_valid,
	input  logic        motor_ready,
	output motor_rate_t motor_1_rate,
	output motor_rate_t motor_2_rate,
	output motor_rate_t motor_3_rate,
	output motor_rate_t motor_4_rate
);

	logic               cmd_xfer;
	logic signed [17:0] t_ext; // Four 16 bit terms need two extra bits
	logic signed [17:0] y_ext;
	logic signed [17:0] r_ext;
	logic signed [17:0] p_ext;

	function automatic motor_rate_t clamp_rate(input logic signed [17:0] sum);
		if (sum < 0) begin
			return '0;
		end else if (sum > 18'sd255) begin
			return 8'hff;
		end
		return motor_rate_t'(sum);
	endfunction

	assign t_ext = $signed({10'b0, throttle_cmd});
	assign y_ext = 18'(yaw_cmd); // Sign extended
	assign r_ext = 18'(roll_cmd);
	assign p_ext = 18'(pitch_cmd);

	assign cmd_ready = !motor_valid || motor_ready;
	assign cmd_xfer  = cmd_valid && cmd_ready;

	// X frame, motors 1 and 2 at the front, diagonal pairs share the yaw sign
	always_ff @(posedge sys_clk) begin
		if (cmd_xfer) begin
			motor_1_rate <= clamp_rate(t_ext + p_ext + r_ext - y_ext);
			motor_2_rate <= clamp_rate(t_ext + p_ext - r_ext + y_ext);
			motor_3_rate <= clamp_rate(t_ext - p_ext - r_ext - y_ext);
			motor_4_rate <= clamp_rate(t_ext - p_ext + r_ext + y_ext);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			motor_valid <= 1'b0;
		end else if (cmd_xfer) begin
			motor_valid <= 1'b1;
		end else if (motor_ready) begin
			motor_valid <= 1'b0;
		end
	end

	mix_hold_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
		motor_valid && !motor_ready |=> motor_valid &&
			$stable({motor_1_rate, motor_2_rate, motor_3_rate, motor_4_rate}))
		else $error("Motor rates changed while the ESC stage stalled");

endmodule

/* source/rate_controller.sv */
`include "drone_params.svh"

module rate_controller import drone_pkg::*; (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       frame_valid,
	output logic       frame_ready,
	input  stick_val_t throttle_val,
	input  stick_val_t yaw_val,
	input  stick_val_t roll_val,
	input  stick_val_t pitch_val,
	input  rate_t      yaw_gyro,
	input  rate_t      roll_gyro,
	input  rate_t      pitch_gyro,
	output logic       cmd_valid,
	input  logic       cmd_ready,
	output stick_val_t throttle_cmd,
	output rate_t      yaw_cmd,
	output rate_t      roll_cmd,
	output rate_t      pitch_cmd
);

	logic frame_xfer;

	// Target rate is the stick offset from center, error is target minus measured rate
	function automatic rate_t axis_cmd(input stick_val_t stick, input rate_t gyro);
		logic signed [16:0] target;
		logic signed [16:0] err;
		target = $signed({9'b0, stick}) - $signed(17'(`STICK_CENTER));
		err = target - 17'(gyro); // One extra bit keeps the difference exact
		return rate_t'(err >>> `P_SHIFT);
	endfunction

	// Take a frame when the output is empty or drains this cycle
	assign frame_ready = !cmd_valid || cmd_ready;
	assign frame_xfer  = frame_valid && frame_ready;

	always_ff @(posedge sys_clk) begin
		if (frame_xfer) begin
			throttle_cmd <= throttle_val; // Throttle is not part of the rate loop
			yaw_cmd      <= axis_cmd(yaw_val, yaw_gyro); // Gyros sampled at the transfer
			roll_cmd     <= axis_cmd(roll_val, roll_gyro);
			pitch_cmd    <= axis_cmd(pitch_val, pitch_gyro);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			cmd_valid <= 1'b0;
		end else if (frame_xfer) begin
			cmd_valid <= 1'b1;
		end else if (cmd_ready) begin
			cmd_valid <= 1'b0;
		end
	end

	// Valid that is not held over from a stall must come from a frame taken last cycle
	cmd_source_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
		cmd_valid && !$past(cmd_valid && !cmd_ready) |-> $past(frame_xfer))
		else $error("Axis command valid without an accepted RC frame");

endmodule

/* source/rc_receiver.sv */
`include "drone_params.svh"

module rc_receiver import drone_pkg::*; (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  logic       us_tick,
	input  logic       throttle_pwm,
	input  logic       yaw_pwm,
	input  logic       roll_pwm,
	input  logic       pitch_pwm,
	output logic       frame_valid,
	input  logic       frame_ready,
	output stick_val_t throttle_val,
	output stick_val_t yaw_val,
	output stick_val_t roll_val,
	output stick_val_t pitch_val
);

	localparam int CNT_W = $clog2(`RC_TIMEOUT_US + 1);

	// Channel order everywhere is throttle, yaw, roll, pitch
	logic [3:0]       pwm_in;
	logic [3:0]       sync_1;
	logic [3:0]       sync_2;
	logic [3:0]       sync_3; // Delayed copy for edge detection
	logic [3:0]       rise;
	logic [3:0]       fall;
	logic [CNT_W-1:0] width_cnt [4]; // Pulse high time in microseconds
	logic [3:0]       dropped; // Pulse ran past timeout, ignore its falling edge
	logic [3:0]       fresh; // Channel has a value not yet moved into the frame
	stick_val_t       staged [4];
	stick_val_t       frame_q [4];
	logic             load_frame;

	assign pwm_in = {pitch_pwm, roll_pwm, yaw_pwm, throttle_pwm};

	// Offset by the minimum width and saturate to the stick range
	function automatic stick_val_t width_to_val(input logic [CNT_W-1:0] width);
		if (width < CNT_W'(`RC_MIN_US)) begin
			return '0;
		end else if (width > CNT_W'(`RC_MIN_US + 255)) begin
			return 8'hff;
		end
		return stick_val_t'(width - CNT_W'(`RC_MIN_US));
	endfunction

	// Two flop synchronizer plus one stage for edge detection
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			sync_1 <= '0;
			sync_2 <= '0;
			sync_3 <= '0;
		end else begin
			sync_1 <= pwm_in;
			sync_2 <= sync_1;
			sync_3 <= sync_2;
		end
	end

	assign rise = sync_2 & ~sync_3;
	assign fall = sync_3 & ~sync_2;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			dropped <= '1; // A pulse already running at reset is not measured
			for (int i = 0; i < 4; i++) begin
				width_cnt[i] <= '0;
			end
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (rise[i]) begin
					width_cnt[i] <= CNT_W'(us_tick); // A tick on the first high cycle counts too
					dropped[i]   <= 1'b0;
				end else if (sync_2[i] && us_tick && !dropped[i]) begin
					if (width_cnt[i] == CNT_W'(`RC_TIMEOUT_US)) begin
						dropped[i]   <= 1'b1;
						width_cnt[i] <= '0;
					end else begin
						width_cnt[i] <= width_cnt[i] + 1'b1;
					end
				end
			end
		end
	end

	// A full frame moves out when the output register is free or being taken
	assign load_frame = (&fresh) && (!frame_valid || frame_ready);

	always_ff @(posedge sys_clk) begin
		for (int i = 0; i < 4; i++) begin
			if (fall[i] && !dropped[i]) begin
				staged[i] <= width_to_val(width_cnt[i]); // Final value on the falling edge
			end
			if (load_frame) begin
				frame_q[i] <= staged[i];
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			fresh       <= '0;
			frame_valid <= 1'b0;
		end else begin
			if (load_frame) begin
				frame_valid <= 1'b1;
			end else if (frame_ready) begin
				frame_valid <= 1'b0;
			end
			for (int i = 0; i < 4; i++) begin
				// A value landing in the load cycle stays fresh for the next frame
				if (fall[i] && !dropped[i]) begin
					fresh[i] <= 1'b1;
				end else if (load_frame) begin
					fresh[i] <= 1'b0;
				end
			end
		end
	end

	assign throttle_val = frame_q[0];
	assign yaw_val      = frame_q[1];
	assign roll_val     = frame_q[2];
	assign pitch_val    = frame_q[3];

	// The presented frame must not move under a stall, even while new pulses arrive
	frame_hold_a: assert property (@(posedge sys_clk) disable iff (!rst_n)
		frame_valid && !frame_ready |=>
			frame_valid && $stable({throttle_val, yaw_val, roll_val, pitch_val}))
		else $error("RC frame changed while stalled");

endmodule

/* source/us_timebase.sv */
`include "drone_params.svh"

module us_timebase (
	input  logic sys_clk,
	input  logic rst_n,
	output logic us_tick
);

	localparam int CNT_W = $clog2(`SYS_CLK_PER_US);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SYS_CLK_PER_US - 1);

	logic [CNT_W-1:0] div_cnt; // Position inside the current microsecond

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (div_cnt == CNT_LAST) begin
			div_cnt <= '0; // Start the next microsecond
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	// One cycle wide strobe on the last cycle of each microsecond
	assign us_tick = (div_cnt == CNT_LAST);

endmodule

/* source/drone_pkg.sv */
package drone_pkg;

	// Decoded RC stick position, 0 at RC_MIN_US and saturating at 255
	typedef logic [7:0] stick_val_t;

	// Signed rotation rate, used both for gyro inputs and axis commands
	typedef logic signed [15:0] rate_t;

	// Motor command added to the ESC minimum pulse width in microseconds
	typedef logic [7:0] motor_rate_t;

endpackage

/* include/drone_params.svh */
`ifndef DRONE_PARAMS_SVH
`define DRONE_PARAMS_SVH

// sys_clk cycles in one microsecond
`define SYS_CLK_PER_US 4

// RC pulse width that decodes to stick value 0
`define RC_MIN_US 1000
// Longest RC pulse still taken as valid
`define RC_TIMEOUT_US 2500

// ESC pulse width for motor rate 0, and the ESC frame period
`define ESC_MIN_US 1000
`define ESC_FRAME_US 2500

// Proportional gain as a right arithmetic shift
`define P_SHIFT 1
// Stick value that asks for zero rotation rate
`define STICK_CENTER 128

`endif
